/* list.f */
+incdir+verif
rtl/clkPkg.sv
rtl/clkDiagIf.sv
rtl/clkDiagPort.sv
rtl/clkConfigRegs.sv
rtl/clkRunCtl.sv
rtl/clkEboxSync.sv
rtl/clkTop.sv
verif/clkTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the clock control testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module clkTb -f list.f -o clkSim
./obj_dir/clkSim

/* verif/clkTests.svh */
  task automatic idle(int n);
    repeat (n) @(posedge MBOX_CLK);
  endtask

  // Reset held for three cycles, phase count restarts
  task automatic applyReset();
    @(posedge MBOX_CLK);
    CLK <= 1'b1;
    repeat (3) @(posedge MBOX_CLK);
    CLK <= 1'b0;
    @(posedge MBOX_CLK);
  endtask

  // Four-phase req/ack with the host side of the handshake
  task automatic hostXfer(diagFuncE f, diagSelT s, diagDataT d, output readDataT r);
    int waitCnt;
    @(posedge MBOX_CLK);
    diagFunc <= f;
    diagSel  <= s;
    diagData <= d;
    diagReq  <= 1'b1;
    waitCnt = 0;
    while (!diagAck) begin
      @(posedge MBOX_CLK);
      waitCnt++;
      if (waitCnt > ackWait) begin
        $display("Handshake: diagAck did not rise within %0d cycles", ackWait);
        stopRun();
      end
    end
    r = diagReadData;
    diagReq <= 1'b0;
    waitCnt = 0;
    while (diagAck) begin
      @(posedge MBOX_CLK);
      waitCnt++;
      if (waitCnt > ackWait) begin
        $display("Handshake: diagAck did not fall within %0d cycles", ackWait);
        stopRun();
      end
    end
  endtask

  task automatic sendCtl(diagSelT s);
    readDataT rd;
    hostXfer(funcCtl, s, 4'h0, rd);
  endtask

  task automatic loadReg(diagSelT s, diagDataT d);
    readDataT rd;
    hostXfer(funcLoad, s, d, rd);
  endtask

  task automatic readStatus(diagSelT s, output readDataT rd);
    hostXfer(funcRead, s, 4'h0, rd);
  endtask

  // 1. Register readback, upper data bits random
  task automatic regReadback();
    diagDataT rateData;
    diagDataT disData;
    burstCountT cnt;
    readDataT rd;
    applyReset();
    rateData = diagDataT'(randBits(4));
    disData  = diagDataT'(randBits(4));
    cnt      = burstCountT'(randBits(8));
    loadReg(selLdRate, rateData);
    loadReg(selLdDis, disData);
    loadReg(selLdBurstLo, cnt[3:0]);
    loadReg(selLdBurstHi, cnt[7:4]);
    for (int s = 0; s < 8; s++) begin
      readStatus(diagSelT'(s), rd);
      checkRead("diagReadData", rd, readRef(diagSelT'(s), 1'b0, 1'b0, cnt,
                rateData[1:0], clkDisT'(disData[2:0])));
    end
  endtask

  // 2. Single steps at any rate
  task automatic singleSteps();
    int n;
    int base;
    int syncBase;
    timeFieldT t;
    applyReset();
    n = 1 + int'(randBits(4) % 12);
    t = timeFieldT'(randBits(2));
    cramTime <= t;
    loadReg(selLdRate, diagDataT'(randBits(4)));
    base     = clkPulses;
    syncBase = syncPulses;
    repeat (n) sendCtl(selSingleStep);
    idle(4);
    checkCount("eboxClk pulses", clkPulses - base, clkRef(n, t));
    checkCount("eboxSync pulses", syncPulses - syncBase, clkRef(n, t));
  endtask

  // 3. Burst of 0 to 40 ticks
  task automatic burstRun();
    int base;
    int syncBase;
    burstCountT cnt;
    rateSelT rate;
    timeFieldT t;
    readDataT rd;
    applyReset();
    cnt  = burstCountT'(randBits(6) % 41);
    rate = rateSelT'(randBits(2));
    t    = timeFieldT'(randBits(2));
    cramTime <= t;
    loadReg(selLdRate, {2'b00, rate});
    loadReg(selLdBurstLo, cnt[3:0]);
    loadReg(selLdBurstHi, cnt[7:4]);
    base     = clkPulses;
    syncBase = syncPulses;
    sendCtl(selBurst);
    readStatus(selRdRun, rd);
    while (rd[4]) begin
      readStatus(selRdRun, rd);
    end
    checkRead("diagReadData run", rd, readRef(selRdRun, 1'b0, 1'b0, 8'd0, rate, 3'b000));
    checkCount("eboxClk pulses", clkPulses - base, clkRef(int'(cnt), t));
    checkCount("eboxSync pulses", syncPulses - syncBase, clkRef(int'(cnt), t));
    readStatus(selRdBurstHi, rd);
    checkRead("diagReadData burstHi", rd, 6'h00);
    readStatus(selRdBurstLo, rd);
    checkRead("diagReadData burstLo", rd, 6'h00);
  endtask

  // 4. Enables masked by the disable bits
  task automatic enableMasks();
    int n;
    int exp;
    int base[4];
    clkDisT dis;
    timeFieldT t;
    applyReset();
    dis = clkDisT'(randBits(3));
    t   = timeFieldT'(randBits(2));
    n   = 4 + int'(randBits(3));
    cramTime <= t;
    loadReg(selLdDis, {1'b0, dis});
    base = '{clkPulses, crmPulses, edpPulses, ctlPulses};
    repeat (n) sendCtl(selSingleStep);
    idle(4);
    exp = clkRef(n, t);
    checkCount("eboxClk pulses", clkPulses - base[0], exp);
    checkCount("crmClkEn pulses", crmPulses - base[1], dis.crmDis ? 0 : exp);
    checkCount("edpClkEn pulses", edpPulses - base[2], dis.edpDis ? 0 : exp);
    checkCount("ctlClkEn pulses", ctlPulses - base[3], dis.ctlDis ? 0 : exp);
  endtask

  // 5. Free run at a random rate, then stop
  task automatic runAndRate();
    int base;
    int startCyc;
    int ticks;
    rateSelT rate;
    timeFieldT t;
    readDataT rd;
    applyReset();
    rate = rateSelT'(randBits(2));
    t    = timeFieldT'(randBits(2));
    cramTime <= t;
    loadReg(selLdRate, {2'b00, rate});
    base = clkPulses;
    sendCtl(selStart);
    startCyc = cycleCnt;
    idle(120);
    readStatus(selRdRun, rd);
    checkRead("diagReadData run", rd, readRef(selRdRun, 1'b1, 1'b0, 8'd0, rate, 3'b000));
    sendCtl(selStop);
    // Start and stop land the same distance before their returns
    ticks = (cycleCnt - startCyc) >> rate;
    idle(4);
    readStatus(selRdRun, rd);
    checkRead("diagReadData stop", rd, readRef(selRdRun, 1'b0, 1'b0, 8'd0, rate, 3'b000));
    compareNear("eboxClk pulses", clkPulses - base, clkRef(ticks, t), 1);
  endtask

/* verif/clkTb.sv */
`timescale 1ns/100ps

module clkTb import clkPkg::*; ();

  // Sum of the test lengths with margin
  localparam int timeoutCycles = 2000;
  localparam int ackWait       = 8;

  logic      MBOX_CLK;
  logic      CLK;
  logic      diagReq;
  diagFuncE  diagFunc;
  diagSelT   diagSel;
  diagDataT  diagData;
  logic      diagAck;
  readDataT  diagReadData;
  timeFieldT cramTime;
  logic      eboxSync;
  logic      eboxClk;
  logic      crmClkEn;
  logic      edpClkEn;
  logic      ctlClkEn;

  // Written only by the monitor, tests take snapshots
  int clkPulses;
  int crmPulses;
  int edpPulses;
  int ctlPulses;
  int syncPulses;
  int cycleCnt;

  // Sync seen at the previous falling edge
  logic syncQ;

  logic [31:0] lfsr;

  clkTop DUT (.*);

  initial begin
    MBOX_CLK = 1'b0;
    forever #5 MBOX_CLK = ~MBOX_CLK;
  end

  // Outputs are settled at the falling edge
  always @(negedge MBOX_CLK) begin
    cycleCnt++;
    if (eboxClk) clkPulses++;
    if (crmClkEn) crmPulses++;
    if (edpClkEn) edpPulses++;
    if (ctlClkEn) ctlPulses++;
    if (eboxSync) syncPulses++;
    // EBOX clock trails sync by one cycle
    if (!CLK) begin
      checkBit("eboxClk", eboxClk, syncQ);
    end
    syncQ = eboxSync;
    if (cycleCnt >= timeoutCycles) begin
      $display("Timeout: the run went past %0d clock cycles", timeoutCycles);
      stopRun();
    end
  end

  task automatic stopRun();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped at the first error");
  endtask

  // Galois LFSR, one step per bit
  function automatic logic lfsrBit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'hA3000000;
    return b;
  endfunction

  function automatic int unsigned randBits(int n);
    int unsigned r;
    r = 0;
    repeat (n) r = {r[30:0], lfsrBit()};
    return r;
  endfunction

  // EBOX clocks expected from a number of ticks
  function automatic int clkRef(int ticks, timeFieldT t);
    return ticks / (int'(t) + 1);
  endfunction

  // Status word layout per read select
  function automatic readDataT readRef(diagSelT sel, logic goV, logic burstV,
                                       burstCountT cnt, rateSelT rate, clkDisT dis);
    case (sel)
      selRdRun:     return {goV, burstV, cnt == 8'd0, rate, 1'b0};
      selRdBurstHi: return {2'b00, cnt[7:4]};
      selRdBurstLo: return {2'b00, cnt[3:0]};
      selRdDis:     return {3'b000, dis};
      default:      return 6'd0;
    endcase
  endfunction

  task automatic checkRead(string name, readDataT got, readDataT exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkCount(string name, int got, int exp);
    if (got != exp) begin
      $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  task automatic compareNear(string name, int got, int exp, int slack);
    if (got < exp - slack || got > exp + slack) begin
      $display("ERROR %s: got 0x%0h expected 0x%0h +-%0d", name, got, exp, slack);
      stopRun();
    end
  endtask

  `include "clkTests.svh"

  initial begin
    CLK      = 1'b1;
    diagReq  = 1'b0;
    diagFunc = funcCtl;
    diagSel  = '0;
    diagData = '0;
    cramTime = '0;
    lfsr     = 32'hf54d591c;
    repeat (3) @(posedge MBOX_CLK);
    CLK <= 1'b0;
    regReadback();
    repeat (3) singleSteps();
    repeat (2) burstRun();
    enableMasks();
    runAndRate();
    idle(2);
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* rtl/clkTop.sv */
`timescale 1ns/100ps

module clkTop import clkPkg::*; (
  input  logic      MBOX_CLK,
  input  logic      CLK,
  // Diagnostic host port
  input  logic      diagReq,
  input  diagFuncE  diagFunc,
  input  diagSelT   diagSel,
  input  diagDataT  diagData,
  output logic      diagAck,
  output readDataT  diagReadData,
  // Microcode time field
  input  timeFieldT cramTime,
  // EBOX clocking
  output logic      eboxSync,
  output logic      eboxClk,
  output logic      crmClkEn,
  output logic      edpClkEn,
  output logic      ctlClkEn
);

  // Decoded diagnostic strobes
  clkDiagIf diagBus ();

  // Status and steering
  logic       tick;
  logic       go;
  logic       burstActive;
  burstCountT burstCount;
  rateSelT    rateSel;
  clkDisT     clkDis;

  clkDiagPort diagPort (
    .MBOX_CLK     (MBOX_CLK),
    .CLK          (CLK),
    .diagReq      (diagReq),
    .diagFunc     (diagFunc),
    .diagSel      (diagSel),
    .diagData     (diagData),
    .diagAck      (diagAck),
    .diagReadData (diagReadData),
    .diag         (diagBus.port),
    .go           (go),
    .burstActive  (burstActive),
    .rateSel      (rateSel),
    .burstCount   (burstCount),
    .clkDis       (clkDis)
  );

  clkConfigRegs configRegs (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .diag     (diagBus.sink),
    .rateSel  (rateSel),
    .clkDis   (clkDis)
  );

  // Run ticks from the divider, bursts and single steps
  clkRunCtl runCtl (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .diag        (diagBus.sink),
    .rateSel     (rateSel),
    .tick        (tick),
    .go          (go),
    .burstActive (burstActive),
    .burstCount  (burstCount)
  );

  clkEboxSync eboxSyncBlk (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .tick     (tick),
    .cramTime (cramTime),
    .clkDis   (clkDis),
    .eboxSync (eboxSync),
    .eboxClk  (eboxClk),
    .crmClkEn (crmClkEn),
    .edpClkEn (edpClkEn),
    .ctlClkEn (ctlClkEn)
  );

endmodule

/* rtl/clkEboxSync.sv */
`timescale 1ns/100ps

module clkEboxSync import clkPkg::*; (
  input  logic      MBOX_CLK,
  input  logic      CLK,
  input  logic      tick,
  input  timeFieldT cramTime,
  input  clkDisT    clkDis,
  output logic      eboxSync,
  output logic      eboxClk,
  output logic      crmClkEn,
  output logic      edpClkEn,
  output logic      ctlClkEn
);

  // Ticks seen so far in this EBOX cycle
  timeFieldT phase;

  // Last tick of the EBOX cycle
  assign eboxSync = tick && (phase == cramTime);

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      phase   <= '0;
      eboxClk <= 1'b0;
    end else begin
      // EBOX clock one cycle after sync
      eboxClk <= eboxSync;
      if (eboxSync) begin
        phase <= '0;
      end else if (tick) begin
        phase <= phase + 1'b1;
      end
    end
  end

  // Per-board enables, masked by the loaded disables
  assign crmClkEn = eboxClk && !clkDis.crmDis;
  assign edpClkEn = eboxClk && !clkDis.edpDis;
  assign ctlClkEn = eboxClk && !clkDis.ctlDis;

  // Back-to-back EBOX clocks only for one-tick EBOX cycles
  eboxClkSingle: assert property (
    @(posedge MBOX_CLK) disable iff (CLK)
    eboxClk && $past(eboxClk) |-> $past(cramTime) == '0
  ) else $error("eboxClk held high across a multi-tick EBOX cycle");

endmodule

/* rtl/clkRunCtl.sv */
`timescale 1ns/100ps

module clkRunCtl import clkPkg::*; (
  input  logic       MBOX_CLK,
  input  logic       CLK,
  clkDiagIf.sink     diag,
  input  rateSelT    rateSel,
  output logic       tick,
  output logic       go,
  output logic       burstActive,
  output burstCountT burstCount
);

  logic [divW-1:0] divCnt;
  logic [divW-1:0] divMask;
  logic            divFire;
  logic            countZero;
  logic            burstRun;
  logic            runTick;
  logic            burstTick;
  logic            lastBurst;
  logic            startStrobe;
  logic            stopStrobe;
  logic            stepStrobe;
  logic            burstStrobe;

  // Control decode
  assign startStrobe = diag.ctlStrobe && (diag.sel == selStart);
  assign stopStrobe  = diag.ctlStrobe && (diag.sel == selStop);
  assign stepStrobe  = diag.ctlStrobe && (diag.sel == selSingleStep);
  assign burstStrobe = diag.ctlStrobe && (diag.sel == selBurst);

  // Free-running divider
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  // Low rateSel bits all ones, fires once per 2**rateSel cycles
  assign divMask = ~({divW{1'b1}} << rateSel);
  assign divFire = (divCnt & divMask) == divMask;

  assign countZero = (burstCount == '0);
  assign burstRun  = burstActive && !countZero;
  assign runTick   = divFire && (go || burstRun);
  assign burstTick = divFire && burstRun;
  assign lastBurst = burstTick && (burstCount == burstCountT'(1));

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      tick        <= 1'b0;
      go          <= 1'b0;
      burstActive <= 1'b0;
      burstCount  <= '0;
    end else begin
      // A single step ticks once, whatever the rate
      tick <= runTick || stepStrobe;

      if (stopStrobe) begin
        go <= 1'b0;
      end else if (startStrobe) begin
        go <= 1'b1;
      end

      // Stop wins, then the count running out
      if (stopStrobe) begin
        burstActive <= 1'b0;
      end else if (lastBurst || (burstActive && countZero)) begin
        burstActive <= 1'b0;
      end else if (burstStrobe && !countZero) begin
        burstActive <= 1'b1;
      end

      // Nibble loads override the countdown
      if (diag.ldStrobe && diag.sel == selLdBurstLo) begin
        burstCount[3:0] <= diag.data;
      end else if (diag.ldStrobe && diag.sel == selLdBurstHi) begin
        burstCount[7:4] <= diag.data;
      end else if (burstTick) begin
        burstCount <= burstCount - 1'b1;
      end
    end
  end

  noBurstWrap: assert property (
    @(posedge MBOX_CLK) disable iff (CLK)
    countZero |=> burstCount != '1
  ) else $error("burstCount wrapped from zero");

endmodule

/* rtl/clkConfigRegs.sv */
`timescale 1ns/100ps

module clkConfigRegs import clkPkg::*; (
  input  logic    MBOX_CLK,
  input  logic    CLK,
  clkDiagIf.sink  diag,
  output rateSelT rateSel,
  output clkDisT  clkDis
);

  logic ldRate;
  logic ldDis;

  // Load decode, other selects belong to the run control
  assign ldRate = diag.ldStrobe && (diag.sel == selLdRate);
  assign ldDis  = diag.ldStrobe && (diag.sel == selLdDis);

  // Rate select steers the run divider
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rateSel <= '0;
    end else if (ldRate) begin
      // Low two data bits
      rateSel <= diag.data[1:0];
    end
  end

  // EBOX clock disables steer the enable masks
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      clkDis <= '0;
    end else if (ldDis) begin
      // Bit 2 is CRM, bit 1 EDP, bit 0 CTL
      clkDis <= clkDisT'(diag.data[2:0]);
    end
  end

endmodule

/* rtl/clkDiagPort.sv */
`timescale 1ns/100ps

module clkDiagPort import clkPkg::*; (
  input  logic       MBOX_CLK,
  input  logic       CLK,
  input  logic       diagReq,
  input  diagFuncE   diagFunc,
  input  diagSelT    diagSel,
  input  diagDataT   diagData,
  output logic       diagAck,
  output readDataT   diagReadData,
  clkDiagIf.port     diag,
  input  logic       go,
  input  logic       burstActive,
  input  rateSelT    rateSel,
  input  burstCountT burstCount,
  input  clkDisT     clkDis
);

  typedef enum logic [1:0] {
    stIdle,
    stStrobe,
    stAck
  } portStateE;

  portStateE state;

  // Request fields captured when the request is accepted
  diagFuncE  funcQ;
  diagSelT   selQ;
  diagDataT  dataQ;
  readDataT  readWord;

  // Handshake FSM
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      state        <= stIdle;
      diagAck      <= 1'b0;
      diagReadData <= '0;
    end else begin
      case (state)
        stIdle: begin
          if (diagReq) begin
            state <= stStrobe;
          end
        end
        // Strobe cycle, the function lands at this edge
        stStrobe: state <= stAck;
        stAck: begin
          if (!diagAck) begin
            if (diagReq) begin
              diagAck      <= 1'b1;
              diagReadData <= (funcQ == funcRead) ? readWord : '0;
            end else begin
              // Host gave up early
              state <= stIdle;
            end
          end else if (!diagReq) begin
            diagAck      <= 1'b0;
            diagReadData <= '0;
            state        <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      funcQ <= funcCtl;
      selQ  <= '0;
      dataQ <= '0;
    end else if (state == stIdle && diagReq) begin
      funcQ <= diagFunc;
      selQ  <= diagSel;
      dataQ <= diagData;
    end
  end

  // Only the function kind is decoded here
  assign diag.ctlStrobe = (state == stStrobe) && (funcQ == funcCtl);
  assign diag.ldStrobe  = (state == stStrobe) && (funcQ == funcLoad);
  assign diag.sel       = selQ;
  assign diag.data      = dataQ;

  // Status word mux
  always_comb begin
    case (selQ)
      selRdRun:     readWord = {go, burstActive, burstCount == '0, rateSel, 1'b0};
      selRdBurstHi: readWord = {2'b00, burstCount[7:4]};
      selRdBurstLo: readWord = {2'b00, burstCount[3:0]};
      selRdDis:     readWord = {3'b000, clkDis};
      default:      readWord = '0;
    endcase
  end

  // Ack only rises on a request still held by the host
  ackNeedsReq: assert property (
    @(posedge MBOX_CLK) disable iff (CLK)
    $rose(diagAck) |-> $past(diagReq)
  ) else $error("diagAck rose without diagReq");

endmodule

/* rtl/clkDiagIf.sv */
`timescale 1ns/100ps

// One decoded diagnostic transaction
interface clkDiagIf import clkPkg::*; ();

  // One-cycle strobes, at most one per transaction
  logic     ctlStrobe;
  logic     ldStrobe;

  // Select and data held from the request, decoded by each receiver
  diagSelT  sel;
  diagDataT data;

  modport port (
    output ctlStrobe,
    output ldStrobe,
    output sel,
    output data
  );

  modport sink (
    input ctlStrobe,
    input ldStrobe,
    input sel,
    input data
  );

endinterface

/* rtl/clkPkg.sv */
package clkPkg;

  // Diagnostic word layout
  localparam int diagSelW    = 3;
  localparam int diagDataW   = 4;
  localparam int readDataW   = 6;
  localparam int burstCountW = 8;
  localparam int rateSelW    = 2;
  localparam int timeFieldW  = 2;

  // Rate divider spans the slowest rate, 2**3 cycles
  localparam int divW = 3;

  // Function kind, decoded by the diagnostic port
  typedef enum logic [1:0] {
    funcCtl  = 2'd0,
    funcLoad = 2'd1,
    funcRead = 2'd2
  } diagFuncE;

  typedef logic [diagSelW-1:0]    diagSelT;
  typedef logic [diagDataW-1:0]   diagDataT;
  typedef logic [readDataW-1:0]   readDataT;
  typedef logic [burstCountW-1:0] burstCountT;
  typedef logic [rateSelW-1:0]    rateSelT;
  typedef logic [timeFieldW-1:0]  timeFieldT;

  // EBOX clock disables, MSB first as loaded from the data nibble
  typedef struct packed {
    logic crmDis;
    logic edpDis;
    logic ctlDis;
  } clkDisT;

  // Control function selects
  localparam diagSelT selStop       = 3'd0;
  localparam diagSelT selStart      = 3'd1;
  localparam diagSelT selSingleStep = 3'd2;
  localparam diagSelT selBurst      = 3'd5;

  // Load function selects
  localparam diagSelT selLdBurstLo = 3'd2;
  localparam diagSelT selLdBurstHi = 3'd3;
  localparam diagSelT selLdRate    = 3'd4;
  localparam diagSelT selLdDis     = 3'd5;

  // Read function selects, others read as zero
  localparam diagSelT selRdRun     = 3'd0;
  localparam diagSelT selRdBurstHi = 3'd1;
  localparam diagSelT selRdBurstLo = 3'd2;
  localparam diagSelT selRdDis     = 3'd3;

endpackage
